/* filelist.f */
hdl/mac_pkg.sv
hdl/short_ctrl_if.sv
hdl/short_mul_if.sv
hdl/mulh_sequencer.sv
hdl/short_mul_cache.sv
hdl/short_mac_datapath.sv
hdl/int_mac_result.sv
hdl/mult_top.sv
tests/mult_top_chk.sv
tests/mult_top_tb.sv

/* hdl/int_mac_result.sv */
/*
  integer MAC and result select
  32-bit multiply-accumulate or multiply-subtract and final output mux
*/
`timescale 1ns/1ps

module int_mac_result (
  input  mac_pkg::mul_opcode_e       operator_i,
  input  logic [mac_pkg::WORD_W-1:0] op_a_i,
  input  logic [mac_pkg::WORD_W-1:0] op_b_i,
  input  logic [mac_pkg::WORD_W-1:0] op_c_i,
  input  logic [mac_pkg::WORD_W-1:0] short_result_i,
  output logic [mac_pkg::WORD_W-1:0] result_o
);
  import mac_pkg::*;

  logic              is_msu;
  logic [WORD_W-1:0] a_msu;
  logic [WORD_W-1:0] b_corr;
  logic [WORD_W-1:0] int_result;

  //////////////////////////////////////////////////
  // 32x32 mac
  //////////////////////////////////////////////////

  assign is_msu = (operator_i == MUL_MSU32);

  // -a*b == ~a*b + b, so one multiplier covers both
  assign a_msu  = op_a_i ^ {WORD_W{is_msu}};
  assign b_corr = op_b_i & {WORD_W{is_msu}};

  // low word only, wraps mod 2^32
  assign int_result = op_c_i + b_corr + a_msu * op_b_i;

  //////////////////////////////////////////////////
  // result mux
  //////////////////////////////////////////////////

  always_comb begin
    case (operator_i)
      MUL_MAC32, MUL_MSU32: begin
        result_o = int_result;
      end
      default: begin
        // mul_i, mul_ir and mul_h all come from the short path
        result_o = short_result_i;
      end
    endcase
  end

endmodule

/* hdl/mac_pkg.sv */
/*
  multiply-accumulate unit shared definitions
  datapath widths, product cache geometry, opcode and mulh state encodings
*/
package mac_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  // operand and result word
  localparam int WORD_W = 32;
  // subword half of a word
  localparam int HALF_W = 16;
  // subword plus one sign extension bit
  localparam int SHORT_OP_W = HALF_W + 1;
  // full 17x17 product, also the short accumulate width
  localparam int SHORT_PROD_W = 2 * SHORT_OP_W;
  // shift amount
  localparam int IMM_W = 5;

  // right shift after mulh steps 0 and 2
  localparam logic [IMM_W-1:0] MULH_STEP_SHIFT = IMM_W'(16);

  //////////////////////////////////////////////////
  // product cache
  //////////////////////////////////////////////////

  localparam int CACHE_SIZE  = 8;
  localparam int CACHE_IDX_W = 3;

  //////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////

  typedef enum logic [2:0] {
    MUL_MAC32 = 3'd0,
    MUL_MSU32 = 3'd1,
    MUL_I     = 3'd2,
    MUL_IR    = 3'd3,
    MUL_H     = 3'd4
  } mul_opcode_e;

  // mulh walks idle -> step0 -> step1 -> step2 -> finish
  typedef enum logic [2:0] {
    MULH_IDLE   = 3'd0,
    MULH_STEP0  = 3'd1,
    MULH_STEP1  = 3'd2,
    MULH_STEP2  = 3'd3,
    MULH_FINISH = 3'd4
  } mulh_state_e;

endpackage

/* hdl/mulh_sequencer.sv */
/*
  mulh sequencer
  splits a 32x32 high multiply into four 16x16 steps on the short datapath
  and drives the ready and multicycle flags
*/
`timescale 1ns/1ps

module mulh_sequencer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 enable_i,
  input  mac_pkg::mul_opcode_e operator_i,
  input  logic [1:0]           short_signed_i,
  input  logic                 ex_ready_i,
  short_ctrl_if.sequencer      ctrl,
  output logic                 ready_o,
  output logic                 multicycle_o
);
  import mac_pkg::*;

  mulh_state_e state_q;
  mulh_state_e state_d;
  logic        start;

  // a mulh is accepted only out of idle
  assign start = enable_i && (operator_i == MUL_H);

  //////////////////////////////////////////////////
  // step decode
  //////////////////////////////////////////////////

  always_comb begin
    state_d          = state_q;
    ctrl.active      = 1'b1;
    ctrl.first_step  = 1'b0;
    ctrl.subword     = 2'b00;
    ctrl.signed_sel  = 2'b00;
    ctrl.shift_imm   = '0;
    ctrl.shift_arith = 1'b0;
    ctrl.save_carry  = 1'b0;
    ctrl.clear_carry = 1'b0;
    ready_o          = 1'b0;
    multicycle_o     = 1'b0;

    case (state_q)
      MULH_IDLE: begin
        // single-cycle ops pass straight through
        ctrl.active = 1'b0;
        ready_o     = !start;
        if (start) begin
          state_d = MULH_STEP0;
        end
      end
      MULH_STEP0: begin
        // al*bl, always unsigned and never carries
        multicycle_o    = 1'b1;
        ctrl.first_step = 1'b1;
        ctrl.shift_imm  = MULH_STEP_SHIFT;
        state_d         = MULH_STEP1;
      end
      MULH_STEP1: begin
        // al*bh, signed only if b is, 33 bit sum so keep the carry
        multicycle_o     = 1'b1;
        ctrl.subword     = 2'b10;
        ctrl.signed_sel  = {short_signed_i[1], 1'b0};
        ctrl.shift_arith = 1'b1;
        ctrl.save_carry  = 1'b1;
        state_d          = MULH_STEP2;
      end
      MULH_STEP2: begin
        // ah*bl, signed only if a is
        // top bits get shifted back down, carry no longer needed
        multicycle_o     = 1'b1;
        ctrl.subword     = 2'b01;
        ctrl.signed_sel  = {1'b0, short_signed_i[0]};
        ctrl.shift_imm   = MULH_STEP_SHIFT;
        ctrl.shift_arith = 1'b1;
        ctrl.save_carry  = 1'b1;
        ctrl.clear_carry = 1'b1;
        state_d          = MULH_FINISH;
      end
      MULH_FINISH: begin
        // ah*bh plus partial sum is the answer, hold until ex stage takes it
        ctrl.subword    = 2'b11;
        ctrl.signed_sel = short_signed_i;
        ready_o         = 1'b1;
        if (ex_ready_i) begin
          state_d = MULH_IDLE;
        end
      end
      default: begin
        state_d = MULH_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MULH_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

/* hdl/mult_top.sv */
/*
  multiply-accumulate unit top
  ties the mulh sequencer, short datapath, product cache and integer MAC
*/
`timescale 1ns/1ps

module mult_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       enable_i,
  input  logic [2:0]                 operator_i,
  input  logic                       short_subword_i,
  input  logic [1:0]                 short_signed_i,
  input  logic [mac_pkg::WORD_W-1:0] op_a_i,
  input  logic [mac_pkg::WORD_W-1:0] op_b_i,
  input  logic [mac_pkg::WORD_W-1:0] op_c_i,
  input  logic [mac_pkg::IMM_W-1:0]  imm_i,
  input  logic                       ex_ready_i,
  output logic [mac_pkg::WORD_W-1:0] result_o,
  output logic                       ready_o,
  output logic                       multicycle_o
);
  import mac_pkg::*;

  mul_opcode_e       operator;
  logic [WORD_W-1:0] short_result;

  // raw opcode bits onto the enum
  assign operator = mul_opcode_e'(operator_i);

  short_ctrl_if ctrl_if ();
  short_mul_if  mul_if ();

  //////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////

  mulh_sequencer u_mulh_sequencer (
    .clk            (clk),
    .rst_n          (rst_n),
    .enable_i       (enable_i),
    .operator_i     (operator),
    .short_signed_i (short_signed_i),
    .ex_ready_i     (ex_ready_i),
    .ctrl           (ctrl_if.sequencer),
    .ready_o        (ready_o),
    .multicycle_o   (multicycle_o)
  );

  //////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////

  short_mac_datapath u_short_mac_datapath (
    .clk             (clk),
    .rst_n           (rst_n),
    .operator_i      (operator),
    .op_a_i          (op_a_i),
    .op_b_i          (op_b_i),
    .op_c_i          (op_c_i),
    .imm_i           (imm_i),
    .short_subword_i (short_subword_i),
    .short_signed_i  (short_signed_i),
    .enable_i        (enable_i),
    .ex_ready_i      (ex_ready_i),
    .ctrl            (ctrl_if.datapath),
    .mul             (mul_if.datapath),
    .short_result_o  (short_result)
  );

  // single short multiplier, shared by mul_i/mul_ir and mulh steps
  short_mul_cache u_short_mul_cache (
    .clk   (clk),
    .rst_n (rst_n),
    .mul   (mul_if.cache)
  );

  int_mac_result u_int_mac_result (
    .operator_i     (operator),
    .op_a_i         (op_a_i),
    .op_b_i         (op_b_i),
    .op_c_i         (op_c_i),
    .short_result_i (short_result),
    .result_o       (result_o)
  );

endmodule

/* hdl/short_ctrl_if.sv */
/*
  mulh step controls
  sequencer overrides for the short multiply datapath
*/
`timescale 1ns/1ps

interface short_ctrl_if;
  import mac_pkg::*;

  // high from step0 through finish
  logic             active;
  // step0 accumulates onto zero
  logic             first_step;
  // bit 1 selects upper half of b, bit 0 upper half of a
  logic [1:0]       subword;
  // bit 1 b signed, bit 0 a signed
  logic [1:0]       signed_sel;
  logic [IMM_W-1:0] shift_imm;
  logic             shift_arith;
  // carry bit bookkeeping
  logic             save_carry;
  logic             clear_carry;

  modport sequencer (
    output active, first_step, subword, signed_sel,
    output shift_imm, shift_arith, save_carry, clear_carry
  );

  modport datapath (
    input active, first_step, subword, signed_sel,
    input shift_imm, shift_arith, save_carry, clear_carry
  );

endinterface

/* hdl/short_mac_datapath.sv */
/*
  short multiply-accumulate datapath
  subword select, accumulate with rounding, right shift, and the mulh
  partial sum and carry registers
*/
`timescale 1ns/1ps

module short_mac_datapath (
  input  logic                        clk,
  input  logic                        rst_n,
  input  mac_pkg::mul_opcode_e        operator_i,
  input  logic [mac_pkg::WORD_W-1:0]  op_a_i,
  input  logic [mac_pkg::WORD_W-1:0]  op_b_i,
  input  logic [mac_pkg::WORD_W-1:0]  op_c_i,
  input  logic [mac_pkg::IMM_W-1:0]   imm_i,
  input  logic                        short_subword_i,
  input  logic [1:0]                  short_signed_i,
  input  logic                        enable_i,
  input  logic                        ex_ready_i,
  short_ctrl_if.datapath              ctrl,
  short_mul_if.datapath               mul,
  output logic [mac_pkg::WORD_W-1:0]  short_result_o
);
  import mac_pkg::*;

  logic [1:0]                     subword;
  logic [1:0]                     signed_sel;
  logic [IMM_W-1:0]               shift_amt;
  logic                           shift_arith;
  logic [HALF_W-1:0]              half_a;
  logic [HALF_W-1:0]              half_b;
  logic [WORD_W-1:0]              round_one;
  logic [WORD_W-1:0]              round;
  logic [SHORT_PROD_W-1:0]        acc;
  logic [SHORT_PROD_W-1:0]        mac;
  logic                           msb1;
  logic                           msb0;
  logic signed [SHORT_PROD_W-1:0] shift_in;
  logic [SHORT_PROD_W-1:0]        shift_out;
  logic [WORD_W-1:0]              psum_q;
  logic                           carry_q;
  logic                           psum_load;

  //////////////////////////////////////////////////
  // operand select
  //////////////////////////////////////////////////

  // sequencer takes over the controls during mulh
  assign subword     = ctrl.active ? ctrl.subword : {2{short_subword_i}};
  assign signed_sel  = ctrl.active ? ctrl.signed_sel : short_signed_i;
  assign shift_amt   = ctrl.active ? ctrl.shift_imm : imm_i;
  assign shift_arith = ctrl.active ? ctrl.shift_arith : short_signed_i[0];

  assign half_a = subword[0] ? op_a_i[WORD_W-1:HALF_W] : op_a_i[HALF_W-1:0];
  assign half_b = subword[1] ? op_b_i[WORD_W-1:HALF_W] : op_b_i[HALF_W-1:0];

  // extra top bit is the sign only when that operand is signed
  assign mul.op_a = {signed_sel[0] & half_a[HALF_W-1], half_a};
  assign mul.op_b = {signed_sel[1] & half_b[HALF_W-1], half_b};

  // let the cache learn from short ops only
  assign mul.fill = enable_i && (operator_i inside {MUL_I, MUL_IR, MUL_H});

  //////////////////////////////////////////////////
  // accumulate, round, shift
  //////////////////////////////////////////////////

  // half an lsb at the shift position, 0 for imm of 0
  assign round_one = {{(WORD_W-1){1'b0}}, 1'b1} << imm_i;
  assign round     = (operator_i == MUL_IR) ? {1'b0, round_one[WORD_W-1:1]} : '0;

  always_comb begin
    if (!ctrl.active) begin
      acc = {{2{op_c_i[WORD_W-1]}}, op_c_i};
    end else if (ctrl.first_step) begin
      acc = '0;
    end else begin
      // saved carry acts as the sign of the partial sum
      acc = {carry_q, carry_q, psum_q};
    end
  end

  assign mac = acc + mul.product + {2'b00, round};

  // mulh keeps the two guard bits, normal ops shift a 32 bit value
  assign msb1 = ctrl.active ? mac[SHORT_PROD_W-1] : mac[WORD_W-1];
  assign msb0 = ctrl.active ? mac[WORD_W] : mac[WORD_W-1];

  assign shift_in  = {shift_arith & msb1, shift_arith & msb0, mac[WORD_W-1:0]};
  assign shift_out = shift_in >>> shift_amt;

  assign short_result_o = shift_out[WORD_W-1:0];

  //////////////////////////////////////////////////
  // mulh state
  //////////////////////////////////////////////////

  // steps 0 to 2 feed the next one, finish must not disturb it
  assign psum_load = ctrl.first_step | ctrl.save_carry;

  always_ff @(posedge clk) begin
    if (psum_load) begin
      psum_q <= short_result_o;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      carry_q <= 1'b0;
    end else if (ctrl.save_carry) begin
      carry_q <= !ctrl.clear_carry & mac[WORD_W];
    end else if (ex_ready_i) begin
      // next instruction starts clean
      carry_q <= 1'b0;
    end
  end

endmodule

/* hdl/short_mul_cache.sv */
/*
  short multiplier with product cache
  17x17 signed multiply behind a small direct-mapped cache of past products
*/
`timescale 1ns/1ps

module short_mul_cache (
  input  logic       clk,
  input  logic       rst_n,
  short_mul_if.cache mul
);
  import mac_pkg::*;

  // cache storage, tags are the full operands
  logic [SHORT_OP_W-1:0]   tag_a_q   [CACHE_SIZE];
  logic [SHORT_OP_W-1:0]   tag_b_q   [CACHE_SIZE];
  logic [SHORT_PROD_W-1:0] product_q [CACHE_SIZE];
  logic [CACHE_SIZE-1:0]   valid_q;

  logic [CACHE_IDX_W-1:0]  idx;
  logic                    hit;
  logic                    write;
  logic [SHORT_PROD_W-1:0] computed;

  //////////////////////////////////////////////////
  // lookup
  //////////////////////////////////////////////////

  // cheap hash of the operand low bits
  assign idx = mul.op_a[CACHE_IDX_W-1:0] ^ mul.op_b[CACHE_IDX_W-1:0];

  assign hit = valid_q[idx]
            && (tag_a_q[idx] == mul.op_a)
            && (tag_b_q[idx] == mul.op_b);

  // both operands already sign-extended by the datapath
  assign computed = $signed(mul.op_a) * $signed(mul.op_b);

  // same value either way, only the source differs
  assign mul.product = hit ? product_q[idx] : computed;

  //////////////////////////////////////////////////
  // fill
  //////////////////////////////////////////////////

  // replace whatever sits at the index on a miss
  assign write = mul.fill && !hit;

  always_ff @(posedge clk) begin
    if (write) begin
      tag_a_q[idx]   <= mul.op_a;
      tag_b_q[idx]   <= mul.op_b;
      product_q[idx] <= computed;
    end
  end

  // all entries start out invalid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (write) begin
      valid_q[idx] <= 1'b1;
    end
  end

endmodule

/* hdl/short_mul_if.sv */
/*
  short multiplier link
  operands and fill permission out, product back from the cache
*/
`timescale 1ns/1ps

interface short_mul_if;
  import mac_pkg::*;

  // sign-extended subword operands
  logic [SHORT_OP_W-1:0]   op_a;
  logic [SHORT_OP_W-1:0]   op_b;
  // cache may store a missed product
  logic                    fill;
  logic [SHORT_PROD_W-1:0] product;

  modport datapath (
    output op_a, op_b, fill,
    input  product
  );

  modport cache (
    input  op_a, op_b, fill,
    output product
  );

endinterface

/* tests/mult_top_chk.sv */
/*
  mulh sequencer checks
  handshake timing and finish hold of the mulh sequencer
*/
`timescale 1ns/1ps

module mult_top_chk (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  enable_i,
  input mac_pkg::mul_opcode_e  operator_i,
  input logic                  ex_ready_i,
  input logic                  ready_i,
  input logic                  multicycle_i,
  input mac_pkg::mulh_state_e  state_i
);
  import mac_pkg::*;

  logic accept;

  // mulh taken out of idle
  assign accept = (state_i == MULH_IDLE) && enable_i && (operator_i == MUL_H);

  flags_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n) !(multicycle_i && ready_i)
  ) else $error("multicycle_o and ready_o high in the same cycle");

  // three busy steps before the result
  ready_after_four: assert property (
    @(posedge clk) disable iff (!rst_n) accept |=> !ready_i [*3] ##1 ready_i
  ) else $error("ready_o did not rise 4 cycles after mulh acceptance");

  finish_holds: assert property (
    @(posedge clk) disable iff (!rst_n)
      (state_i == MULH_FINISH && !ex_ready_i) |=> (state_i == MULH_FINISH)
  ) else $error("sequencer left finish while ex_ready_i was low");

endmodule

bind mulh_sequencer mult_top_chk u_mult_top_chk (
  .clk          (clk),
  .rst_n        (rst_n),
  .enable_i     (enable_i),
  .operator_i   (operator_i),
  .ex_ready_i   (ex_ready_i),
  .ready_i      (ready_o),
  .multicycle_i (multicycle_o),
  .state_i      (state_q)
);

/* tests/mult_top_tb.sv */
/*
  multiply-accumulate unit testbench
  directed table of single-cycle and mulh operations followed by a random mulh batch
*/
`timescale 1ns/1ps

module mult_top_tb;
  import mac_pkg::*;

  localparam int          CLK_PERIOD     = 100;
  localparam int          RESET_CYCLES   = 8;
  localparam int          TABLE_ROWS     = 39;
  localparam int          RAND_ROWS      = 20;
  localparam int          MAX_STALL      = 3;
  localparam int          READY_LIMIT    = 8;
  localparam int          TIMEOUT_CYCLES = (TABLE_ROWS + RAND_ROWS) * (6 + MAX_STALL) + 20;
  localparam logic [31:0] SEED           = 32'hb03d;

  logic        clk;
  logic        rst_n;
  logic        enable;
  logic [2:0]  operator;
  logic        short_subword;
  logic [1:0]  short_signed;
  logic [31:0] op_a;
  logic [31:0] op_b;
  logic [31:0] op_c;
  logic [4:0]  imm;
  logic        ex_ready;
  logic [31:0] result;
  logic        ready;
  logic        multicycle;

  // stimulus table with one entry per row
  logic [2:0]  tab_op    [TABLE_ROWS];
  logic [31:0] tab_a     [TABLE_ROWS];
  logic [31:0] tab_b     [TABLE_ROWS];
  logic [31:0] tab_c     [TABLE_ROWS];
  logic [4:0]  tab_imm   [TABLE_ROWS];
  logic        tab_sub   [TABLE_ROWS];
  logic [1:0]  tab_sgn   [TABLE_ROWS];
  int          tab_stall [TABLE_ROWS];
  logic [31:0] tab_exp   [TABLE_ROWS];

  int          row_count;
  int          cur_row;
  int          errors;
  int          checks;
  int          cycles;
  int unsigned seed_init;
  logic [31:0] rand_a;
  logic [31:0] rand_b;
  logic [31:0] rand_c;
  logic [1:0]  rand_sgn;
  int          rand_stall;

  mult_top UUT (
    .clk             (clk),
    .rst_n           (rst_n),
    .enable_i        (enable),
    .operator_i      (operator),
    .short_subword_i (short_subword),
    .short_signed_i  (short_signed),
    .op_a_i          (op_a),
    .op_b_i          (op_b),
    .op_c_i          (op_c),
    .imm_i           (imm),
    .ex_ready_i      (ex_ready),
    .result_o        (result),
    .ready_o         (ready),
    .multicycle_o    (multicycle)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR %s expected 0x%08h actual 0x%08h (row %0d, %0t)",
               name, expected, actual, cur_row, $time);
    end
  endtask

  // upper word of the full 64 bit product
  // sgn bit 0 makes a signed and bit 1 makes b signed
  function automatic logic [31:0] mulh_upper(input logic [31:0] a, input logic [31:0] b,
                                             input logic [1:0] sgn);
    logic signed [32:0] ax;
    logic signed [32:0] bx;
    logic signed [65:0] prod;
    ax   = {sgn[0] & a[31], a};
    bx   = {sgn[1] & b[31], b};
    prod = ax * bx;
    return prod[63:32];
  endfunction

  task automatic add_row(input logic [2:0] op, input logic [31:0] a, input logic [31:0] b,
                         input logic [31:0] c, input logic [4:0] imm_v, input logic sub,
                         input logic [1:0] sgn, input int stall, input logic [31:0] exp);
    tab_op[row_count]    = op;
    tab_a[row_count]     = a;
    tab_b[row_count]     = b;
    tab_c[row_count]     = c;
    tab_imm[row_count]   = imm_v;
    tab_sub[row_count]   = sub;
    tab_sgn[row_count]   = sgn;
    tab_stall[row_count] = stall;
    tab_exp[row_count]   = exp;
    row_count++;
  endtask

  // op, a, b, c, imm, subword, signed, stall, expected
  task automatic load_table();
    row_count = 0;
    add_row(MUL_MAC32, 32'h3,        32'h5,        32'ha,        0, 0, 2'b00, 0, 32'h19);
    add_row(MUL_MAC32, 32'hffffffff, 32'h2,        32'h1,        0, 0, 2'b00, 0, 32'hffffffff);
    add_row(MUL_MAC32, 32'h00010000, 32'h00010000, 32'h12345678, 0, 0, 2'b00, 0, 32'h12345678);
    add_row(MUL_MSU32, 32'h3,        32'h5,        32'h64,       0, 0, 2'b00, 0, 32'h55);
    add_row(MUL_MSU32, 32'h7,        32'h6,        32'h0,        0, 0, 2'b00, 0, 32'hffffffd6);
    add_row(MUL_MSU32, 32'h80000000, 32'h1,        32'h0,        0, 0, 2'b00, 0, 32'h80000000);
    // subword select, signedness, shift kind
    add_row(MUL_I,     32'h00050003, 32'h00070004, 32'h10,       0, 0, 2'b00, 0, 32'h1c);
    add_row(MUL_I,     32'h00050003, 32'h00070004, 32'h0,        0, 1, 2'b00, 0, 32'h23);
    add_row(MUL_I,     32'h0000ffff, 32'h2,        32'h0,        0, 0, 2'b11, 0, 32'hfffffffe);
    add_row(MUL_I,     32'h0000ffff, 32'h2,        32'h0,        0, 0, 2'b00, 0, 32'h0001fffe);
    add_row(MUL_I,     32'h0000ffff, 32'h00008000, 32'h0,        4, 0, 2'b01, 0, 32'hfffff800);
    add_row(MUL_I,     32'h2,        32'h0000ffff, 32'h0,        4, 0, 2'b10, 0, 32'h0fffffff);
    add_row(MUL_I,     32'h10,       32'h1,        32'hfffffff0, 0, 0, 2'b00, 0, 32'h0);
    add_row(MUL_I,     32'h0,        32'h0,        32'h80000000, 4, 0, 2'b00, 0, 32'h08000000);
    add_row(MUL_I,     32'h0,        32'h0,        32'h80000000, 4, 0, 2'b01, 0, 32'hf8000000);
    add_row(MUL_I,     32'hffff1234, 32'h0003abcd, 32'h0,        0, 1, 2'b11, 0, 32'hfffffffd);
    // rounding
    add_row(MUL_IR,    32'h3,        32'h3,        32'h0,        1, 0, 2'b00, 0, 32'h5);
    add_row(MUL_IR,    32'h7,        32'h1,        32'h0,        2, 0, 2'b00, 0, 32'h2);
    add_row(MUL_I,     32'h7,        32'h1,        32'h0,        2, 0, 2'b00, 0, 32'h1);
    add_row(MUL_IR,    32'h5,        32'h5,        32'h1,        0, 0, 2'b00, 0, 32'h1a);
    add_row(MUL_IR,    32'h0000ffff, 32'h5,        32'h0,        2, 0, 2'b11, 0, 32'hffffffff);
    // mulh ignores op_c
    add_row(MUL_H,     32'h2,        32'h3,        32'hffffffff, 0, 0, 2'b00, 0, 32'h0);
    add_row(MUL_H,     32'hffffffff, 32'hffffffff, 32'hffffffff, 0, 0, 2'b00, 0, 32'hfffffffe);
    add_row(MUL_H,     32'hffffffff, 32'hffffffff, 32'hffffffff, 0, 0, 2'b11, 0, 32'h0);
    add_row(MUL_H,     32'hffffffff, 32'hffffffff, 32'hffffffff, 0, 0, 2'b01, 0, 32'hffffffff);
    add_row(MUL_H,     32'h80000000, 32'h80000000, 32'h0,        0, 0, 2'b11, 0, 32'h40000000);
    add_row(MUL_H,     32'h12345678, 32'h00010000, 32'h0,        0, 0, 2'b11, 3, 32'h00001234);
    add_row(MUL_H,     32'h80000000, 32'h2,        32'h0,        0, 0, 2'b00, 1, 32'h1);
    add_row(MUL_H,     32'hfffffffe, 32'h3,        32'h0,        0, 0, 2'b11, 2, 32'hffffffff);
    add_row(MUL_H,     32'h7fffffff, 32'h7fffffff, 32'h0,        0, 0, 2'b11, 0, 32'h3fffffff);
    // cache index 6 repeated, then a collision, then the first operands again
    add_row(MUL_I,     32'h5,        32'h3,        32'h0,        0, 0, 2'b00, 0, 32'hf);
    add_row(MUL_I,     32'h5,        32'h3,        32'h0,        0, 0, 2'b00, 0, 32'hf);
    add_row(MUL_I,     32'he,        32'h8,        32'h0,        0, 0, 2'b00, 0, 32'h70);
    add_row(MUL_I,     32'hd,        32'hb,        32'h0,        0, 0, 2'b00, 0, 32'h8f);
    add_row(MUL_I,     32'h5,        32'h3,        32'h0,        0, 0, 2'b00, 0, 32'hf);
    add_row(MUL_I,     32'h5,        32'h3,        32'h100,      0, 0, 2'b00, 0, 32'h10f);
    // same halves with a different sign bit in the tag
    add_row(MUL_I,     32'h0000ffff, 32'h1,        32'h0,        0, 0, 2'b00, 0, 32'h0000ffff);
    add_row(MUL_I,     32'h0000ffff, 32'h1,        32'h0,        0, 0, 2'b01, 0, 32'hffffffff);
    add_row(MUL_I,     32'h0000ffff, 32'h1,        32'h0,        0, 0, 2'b00, 0, 32'h0000ffff);
  endtask

  task automatic apply_inputs(input logic [2:0] op, input logic [31:0] a, input logic [31:0] b,
                              input logic [31:0] c, input logic [4:0] imm_v, input logic sub,
                              input logic [1:0] sgn);
    enable        = 1'b1;
    operator      = op;
    op_a          = a;
    op_b          = b;
    op_c          = c;
    imm           = imm_v;
    short_subword = sub;
    short_signed  = sgn;
  endtask

  //////////////////////////////////////////////////
  // row runners
  //////////////////////////////////////////////////

  // result checked before the clock edge and again after a possible cache fill
  task automatic run_single(input int idx);
    apply_inputs(tab_op[idx], tab_a[idx], tab_b[idx], tab_c[idx], tab_imm[idx],
                 tab_sub[idx], tab_sgn[idx]);
    ex_ready = 1'b1;
    #(CLK_PERIOD/4);
    compare_value("result_o", tab_exp[idx], result);
    compare_value("ready_o", 32'd1, ready);
    @(negedge clk);
    compare_value("result_o", tab_exp[idx], result);
    compare_value("ready_o", 32'd1, ready);
    compare_value("multicycle_o", 32'd0, multicycle);
  endtask

  task automatic run_mulh(input logic [31:0] a, input logic [31:0] b, input logic [31:0] c,
                          input logic [1:0] sgn, input int stall, input logic [31:0] exp);
    int waited;
    int busy;
    apply_inputs(MUL_H, a, b, c, 5'd0, 1'b0, sgn);
    ex_ready = (stall == 0);
    #(CLK_PERIOD/4);
    compare_value("ready_o", 32'd0, ready);
    waited = 0;
    busy   = 0;
    while (!ready && waited < READY_LIMIT) begin
      @(negedge clk);
      waited++;
      if (multicycle) begin
        busy++;
      end
    end
    if (!ready) begin
      errors++;
      $display("row %0d: ready_o never came back high after the mulh was accepted", cur_row);
    end else begin
      compare_value("ready_o latency", 32'd4, waited);
      compare_value("multicycle_o cycles", 32'd3, busy);
      compare_value("result_o", exp, result);
    end
    // result must not move while held in finish
    repeat (stall) begin
      @(negedge clk);
      compare_value("ready_o", 32'd1, ready);
      compare_value("multicycle_o", 32'd0, multicycle);
      compare_value("result_o", exp, result);
    end
  endtask

  // release the result and let the sequencer fall back to idle
  task automatic return_to_idle();
    enable   = 1'b0;
    ex_ready = 1'b1;
    @(negedge clk);
    compare_value("ready_o", 32'd1, ready);
    compare_value("multicycle_o", 32'd0, multicycle);
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    seed_init     = $urandom(SEED);
    rst_n         = 1'b0;
    enable        = 1'b0;
    operator      = MUL_MAC32;
    short_subword = 1'b0;
    short_signed  = 2'b00;
    op_a          = '0;
    op_b          = '0;
    op_c          = '0;
    imm           = '0;
    ex_ready      = 1'b1;
    errors        = 0;
    checks        = 0;
    cur_row       = -1;
    load_table();

    // eight rising edges under reset
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    compare_value("ready_o", 32'd1, ready);
    compare_value("multicycle_o", 32'd0, multicycle);

    for (int i = 0; i < TABLE_ROWS; i++) begin
      cur_row = i;
      if (tab_op[i] == MUL_H) begin
        run_mulh(tab_a[i], tab_b[i], tab_c[i], tab_sgn[i], tab_stall[i], tab_exp[i]);
      end else begin
        run_single(i);
      end
      return_to_idle();
    end

    // random mulh, mulhsu and mulhu
    for (int i = 0; i < RAND_ROWS; i++) begin
      cur_row = TABLE_ROWS + i;
      rand_a  = $urandom;
      rand_b  = $urandom;
      rand_c  = $urandom;
      case ($urandom % 3)
        0: rand_sgn = 2'b00;
        1: rand_sgn = 2'b01;
        default: rand_sgn = 2'b11;
      endcase
      rand_stall = $urandom % (MAX_STALL + 1);
      run_mulh(rand_a, rand_b, rand_c, rand_sgn, rand_stall,
               mulh_upper(rand_a, rand_b, rand_sgn));
      return_to_idle();
    end

    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // run limit scaled to the number of rows
  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("Test failed");
    $finish;
  end

endmodule
